/* vlog.f */
+incdir+test
rtl/xc_pkg.sv
rtl/xc_sampler.sv
rtl/xc_auto_counters.sv
rtl/xc_cross_counters.sv
rtl/xc_readout_axil.sv
rtl/xc_top.sv
test/xc_tb.sv

/* run.sh */
#!/bin/sh
# Builds the correlator testbench with Verilator and runs it.
# Exits non-zero unless the run reports a pass.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module xc_tb -o xc_tb_sim

out=$(./obj_dir/xc_tb_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Test passed"; then
	exit 0
fi
exit 1

/* test/xc_tb_axil.svh */
// AXI4-Lite master tasks and LFSR step for the correlator testbench.
// Included inside xc_tb; uses its bus signals, clki and check_eq.
// Tasks start and end 1 ns after a rising edge and sample on falling edges.

`ifndef XC_TB_AXIL_SVH
`define XC_TB_AXIL_SVH

// Fibonacci LFSR, taps 32, 22, 2, 1.
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// ############################
// Write channel.
// ############################

// Address and data raised together, response taken with bready.
task automatic write_reg(input logic [7:0] addr, input logic [31:0] data, output logic [1:0] resp);
	awaddr  = addr;
	wdata   = data;
	wstrb   = 4'hf;
	awvalid = 1'b1;
	wvalid  = 1'b1;
	@(negedge clki);
	while (!(awready && wready)) @(negedge clki);
	@(posedge clki);
	#1;
	awvalid = 1'b0;
	wvalid  = 1'b0;
	bready  = 1'b1;
	@(negedge clki);
	while (!bvalid) @(negedge clki);
	resp = bresp;
	@(posedge clki);
	#1;
	bready = 1'b0;
endtask

// ############################
// Read channel.
// ############################

// Holds rready low for hold cycles once rvalid is up.
task automatic read_reg(input logic [7:0] addr, input int hold, output logic [31:0] data);
	araddr  = addr;
	arvalid = 1'b1;
	@(negedge clki);
	while (!arready) @(negedge clki);
	@(posedge clki);
	#1;
	arvalid = 1'b0;
	// Address moves on once accepted.
	araddr  = REG_STATUS;
	@(negedge clki);
	while (!rvalid) @(negedge clki);
	data = rdata;
	check_eq($sformatf("rresp at %h", addr), {30'd0, rresp}, 32'd0);
	repeat (hold) begin
		@(negedge clki);
		check_eq($sformatf("rvalid held at %h", addr), {31'd0, rvalid}, 32'd1);
		check_eq($sformatf("rdata held at %h", addr), rdata, data);
	end
	@(posedge clki);
	#1;
	rready = 1'b1;
	@(posedge clki);
	#1;
	rready = 1'b0;
endtask

`endif

/* test/xc_tb.sv */
// Table-driven testbench for the correlator core over AXI4-Lite.
// Each table row is one integration; counts come from a model of the driven lines.
// Assumes NUM_LINES 4 for the fixed patterns; the run ends on a cycle limit.

`timescale 1ns/100ps
`default_nettype none

module xc_tb
	import xc_pkg::*;
;

	localparam int NUM_LINES = 4;
	localparam int MAX_LAG = 2;
	localparam int COUNT_W = 24;
	localparam int NUM_PAIRS = NUM_LINES * (NUM_LINES - 1) / 2;
	localparam int NUM_CROSS = NUM_PAIRS * MAX_LAG;
	localparam int NUM_ROWS = 4;

	// ############################
	// Stimulus table.
	// ############################

	// Divider, samples per integration, LFSR or fixed lines.
	int row_div [NUM_ROWS] = '{0, 0, 3, 3};
	int row_samples [NUM_ROWS] = '{20, 24, 12, 16};
	bit row_lfsr [NUM_ROWS] = '{1'b0, 1'b1, 1'b0, 1'b1};

	logic [NUM_LINES-1:0] fixed_pat [8] = '{4'b1011, 4'b0110, 4'b1101, 4'b0001,
		4'b1111, 4'b0000, 4'b1010, 4'b0111};

	// DUT signals.
	logic                 clki;
	logic                 rst;
	logic [NUM_LINES-1:0] line_in;
	logic                 integrating;
	logic [7:0]           awaddr;
	logic                 awvalid;
	logic                 awready;
	logic [31:0]          wdata;
	logic [3:0]           wstrb;
	logic                 wvalid;
	logic                 wready;
	logic [1:0]           bresp;
	logic                 bvalid;
	logic                 bready;
	logic [7:0]           araddr;
	logic                 arvalid;
	logic                 arready;
	logic [31:0]          rdata;
	logic [1:0]           rresp;
	logic                 rvalid;
	logic                 rready;
	logic                 snap_irq;

	// Model state and bookkeeping.
	logic [NUM_LINES-1:0] vals [$];
	int                   auto_exp [NUM_LINES];
	int                   cross_exp [NUM_CROSS];
	logic [31:0]          lfsr_state;
	int                   errors = 0;
	int                   checks = 0;
	int                   tests = 0;
	int                   test_err_start = 0;
	int                   test_chk_start = 0;
	int                   irq_count = 0;
	int                   cycles = 0;
	int                   cycle_limit = 0;

	xc_top #(
		.NUM_LINES(NUM_LINES),
		.MAX_LAG  (MAX_LAG),
		.COUNT_W  (COUNT_W)
	) u_xc_top (
		.clki(clki), .rst(rst), .line_in(line_in), .integrating(integrating),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.snap_irq(snap_irq)
	);

	initial begin
		clki = 1'b0;
		forever #2 clki = ~clki;
	end

	// Watchdog.
	always @(posedge clki) begin
		cycles++;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("Test failed");
			$finish;
		end
	end

	// Interrupt pulses, sampled mid-cycle.
	always @(negedge clki) begin
		if (snap_irq === 1'b1) begin
			irq_count++;
		end
	end

	task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("ERROR: %0t %s got %h expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	`include "xc_tb_axil.svh"

	task automatic wait_cycles(input int n);
		repeat (n) begin
			@(posedge clki);
			#1;
		end
	endtask

	task automatic report_test(input string name);
		$display("%-32s %0d checks, %0d errors", name, checks - test_chk_start,
			errors - test_err_start);
		test_chk_start = checks;
		test_err_start = errors;
		tests++;
	endtask

	// Twice the sampled cycles of the table, plus slack for bus traffic.
	function automatic int run_limit();
		int sum;
		sum = 0;
		for (int r = 0; r < NUM_ROWS; r++) begin
			sum += row_samples[r] * (row_div[r] + 1);
		end
		return 2 * sum + 2000;
	endfunction

	// One LFSR step per line bit.
	function automatic logic [NUM_LINES-1:0] draw_pattern();
		logic [NUM_LINES-1:0] p;
		for (int b = 0; b < NUM_LINES; b++) begin
			p[b]       = lfsr_state[31];
			lfsr_state = lfsr_next(lfsr_state);
		end
		return p;
	endfunction

	// Ones per line and lagged coincidences; history before sample 0 is zero.
	function automatic void build_model();
		int pidx;
		foreach (auto_exp[i]) auto_exp[i] = 0;
		foreach (cross_exp[c]) cross_exp[c] = 0;
		for (int k = 0; k < vals.size(); k++) begin
			for (int i = 0; i < NUM_LINES; i++) begin
				if (vals[k][i]) auto_exp[i]++;
				for (int j = i + 1; j < NUM_LINES; j++) begin
					pidx = xc_pair_index(i, j, NUM_LINES);
					for (int l = 0; l < MAX_LAG && l <= k; l++) begin
						if (vals[k][i] && vals[k - l][j]) cross_exp[pidx * MAX_LAG + l]++;
					end
				end
			end
		end
	endfunction

	initial begin
		logic [1:0]           resp;
		logic [31:0]          rd;
		logic [31:0]          ctrl;
		logic [NUM_LINES-1:0] pat;
		int                   period;
		cycle_limit = run_limit();
		lfsr_state  = 32'hb90210c0;
		rst         = 1'b1;
		line_in     = '0;
		integrating = 1'b0;
		awaddr      = '0;
		awvalid     = 1'b0;
		wdata       = '0;
		wstrb       = '0;
		wvalid      = 1'b0;
		bready      = 1'b0;
		araddr      = '0;
		arvalid     = 1'b0;
		rready      = 1'b0;
		repeat (3) @(posedge clki);
		#1;
		rst = 1'b0;
		wait_cycles(2);

		// ############################
		// Reset and register access.
		// ############################
		read_reg(REG_STATUS, 0, rd);
		check_eq("status after reset", rd, 32'd0);
		read_reg(REG_CTRL, 0, rd);
		check_eq("ctrl after reset", rd, 32'd0);
		wait_cycles(20);
		check_eq("snap_irq while disabled", 32'(irq_count), 32'd0);
		report_test("reset defaults");

		write_reg(REG_CTRL, 32'h0000_0001, resp);
		check_eq("ctrl write resp", {30'd0, resp}, 32'd0);
		read_reg(REG_CTRL, 0, rd);
		check_eq("ctrl readback", rd, 32'h0000_0001);
		write_reg(REG_STATUS, 32'hffff_ffff, resp);
		check_eq("status write resp", {30'd0, resp}, 32'd0);
		read_reg(REG_STATUS, 0, rd);
		check_eq("status after write", rd, 32'd0);
		// Control keeps its value when another offset is written.
		read_reg(REG_CTRL, 0, rd);
		check_eq("ctrl after status write", rd, 32'h0000_0001);
		read_reg(8'h30, 0, rd);
		check_eq("unmapped read", rd, 32'd0);
		report_test("register access");

		// ############################
		// Integrations.
		// ############################
		for (int r = 0; r < NUM_ROWS; r++) begin
			period = row_div[r] + 1;
			ctrl   = {16'd0, 8'(row_div[r]), 8'd1};
			write_reg(REG_CTRL, ctrl, resp);
			read_reg(REG_CTRL, 0, rd);
			check_eq("ctrl readback", rd, ctrl);
			// Zeros flush the lag history.
			line_in = '0;
			wait_cycles(MAX_LAG * period);
			vals.delete();
			integrating = 1'b1;
			for (int k = 0; k < row_samples[r]; k++) begin
				pat = row_lfsr[r] ? draw_pattern() : fixed_pat[k % 8];
				vals.push_back(pat);
				line_in = pat;
				wait_cycles(period);
			end
			integrating = 1'b0;
			line_in     = '0;
			build_model();
			while (!snap_irq) @(negedge clki);
			wait_cycles(1);
			read_reg(REG_STATUS, 0, rd);
			check_eq("status", rd, {1'b1, 15'd0, 16'(r + 1)});
			check_eq("snap_irq count", 32'(irq_count), 32'(r + 1));
			for (int i = 0; i < NUM_LINES; i++) begin
				read_reg(REG_AUTO_BASE + 8'(4 * i), 0, rd);
				check_eq($sformatf("auto line %0d", i), rd, 32'(auto_exp[i]));
			end
			for (int c = 0; c < NUM_CROSS; c++) begin
				read_reg(REG_CROSS_BASE + 8'(4 * c), 0, rd);
				check_eq($sformatf("cross slot %0d", c), rd, 32'(cross_exp[c]));
			end
			report_test($sformatf("integration %0d div %0d %s", r, row_div[r],
				row_lfsr[r] ? "lfsr" : "fixed"));
		end

		// Response must hold while rready stays low.
		read_reg(REG_CROSS_BASE, 6, rd);
		check_eq("cross slot 0 under back-pressure", rd, 32'(cross_exp[0]));
		report_test("read back-pressure");

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* rtl/xc_top.sv */
// Correlator core: sampler, auto and cross counter banks, AXI4-Lite readout.
// line_in and integrating are asynchronous; everything else is on clki.
// Needs NUM_LINES of at least 2 and COUNT_W of at most 32.

`timescale 1ns/100ps
`default_nettype none

module xc_top
	import xc_pkg::*;
#(
	parameter int NUM_LINES = 4,
	parameter int MAX_LAG = 2,
	parameter int COUNT_W = 24,
	localparam int NUM_PAIRS = xc_pair_index(NUM_LINES - 2, NUM_LINES - 1, NUM_LINES) + 1,
	localparam int NUM_CROSS = NUM_PAIRS * MAX_LAG
) (
	input  wire logic                       clki,
	input  wire logic                       rst,
	input  wire logic [NUM_LINES-1:0]       line_in,
	input  wire logic                       integrating,

	input  wire logic [AXIL_ADDR_W-1:0]     awaddr,
	input  wire logic                       awvalid,
	output logic                            awready,
	input  wire logic [AXIL_DATA_W-1:0]     wdata,
	input  wire logic [AXIL_DATA_W/8-1:0]   wstrb,
	input  wire logic                       wvalid,
	output logic                            wready,
	output logic      [1:0]                 bresp,
	output logic                            bvalid,
	input  wire logic                       bready,
	input  wire logic [AXIL_ADDR_W-1:0]     araddr,
	input  wire logic                       arvalid,
	output logic                            arready,
	output logic      [AXIL_DATA_W-1:0]     rdata,
	output logic      [1:0]                 rresp,
	output logic                            rvalid,
	input  wire logic                       rready,

	output logic                            snap_irq
);

	// Sample stream.
	logic                           sample_valid;
	logic [NUM_LINES*MAX_LAG-1:0]   sample_hist;
	logic                           integ_active;
	logic                           integ_end;

	// Live counts and control.
	logic [NUM_LINES*COUNT_W-1:0]   auto_counts;
	logic [NUM_CROSS*COUNT_W-1:0]   cross_counts;
	logic                           enable;
	logic [7:0]                     sample_div;

	xc_sampler #(
		.NUM_LINES(NUM_LINES),
		.MAX_LAG  (MAX_LAG)
	) u_sampler (
		.clki        (clki),
		.rst         (rst),
		.line_in     (line_in),
		.integrating (integrating),
		.enable      (enable),
		.sample_div  (sample_div),
		.sample_valid(sample_valid),
		.sample_hist (sample_hist),
		.integ_active(integ_active),
		.integ_end   (integ_end)
	);

	xc_auto_counters #(
		.NUM_LINES(NUM_LINES),
		.MAX_LAG  (MAX_LAG),
		.COUNT_W  (COUNT_W)
	) u_auto (
		.clki        (clki),
		.rst         (rst),
		.sample_valid(sample_valid),
		.sample_hist (sample_hist),
		.integ_active(integ_active),
		.integ_end   (integ_end),
		.auto_counts (auto_counts)
	);

	xc_cross_counters #(
		.NUM_LINES(NUM_LINES),
		.MAX_LAG  (MAX_LAG),
		.COUNT_W  (COUNT_W)
	) u_cross (
		.clki        (clki),
		.rst         (rst),
		.sample_valid(sample_valid),
		.sample_hist (sample_hist),
		.integ_active(integ_active),
		.integ_end   (integ_end),
		.cross_counts(cross_counts)
	);

	xc_readout_axil #(
		.NUM_LINES(NUM_LINES),
		.MAX_LAG  (MAX_LAG),
		.COUNT_W  (COUNT_W)
	) u_readout (
		.clki        (clki),
		.rst         (rst),
		.auto_counts (auto_counts),
		.cross_counts(cross_counts),
		.integ_end   (integ_end),
		.awaddr      (awaddr),
		.awvalid     (awvalid),
		.awready     (awready),
		.wdata       (wdata),
		.wstrb       (wstrb),
		.wvalid      (wvalid),
		.wready      (wready),
		.bresp       (bresp),
		.bvalid      (bvalid),
		.bready      (bready),
		.araddr      (araddr),
		.arvalid     (arvalid),
		.arready     (arready),
		.rdata       (rdata),
		.rresp       (rresp),
		.rvalid      (rvalid),
		.rready      (rready),
		.enable      (enable),
		.sample_div  (sample_div),
		.snap_irq    (snap_irq)
	);

endmodule

`default_nettype wire

/* rtl/xc_readout_axil.sv */
// Snapshot registers, control register and AXI4-Lite slave.
// One write and one read in flight at a time. Responses are always OKAY.
// COUNT_W must not exceed 32; counts are zero-extended on read.

`timescale 1ns/100ps
`default_nettype none

module xc_readout_axil
	import xc_pkg::*;
#(
	parameter int NUM_LINES = 4,
	parameter int MAX_LAG = 2,
	parameter int COUNT_W = 24,
	localparam int NUM_PAIRS = xc_pair_index(NUM_LINES - 2, NUM_LINES - 1, NUM_LINES) + 1,
	localparam int NUM_CROSS = NUM_PAIRS * MAX_LAG
) (
	input  wire logic                           clki,
	input  wire logic                           rst,
	input  wire logic [NUM_LINES*COUNT_W-1:0]   auto_counts,
	input  wire logic [NUM_CROSS*COUNT_W-1:0]   cross_counts,
	input  wire logic                           integ_end,

	// Write address and data.
	input  wire logic [AXIL_ADDR_W-1:0]         awaddr,
	input  wire logic                           awvalid,
	output logic                                awready,
	input  wire logic [AXIL_DATA_W-1:0]         wdata,
	input  wire logic [AXIL_DATA_W/8-1:0]       wstrb,
	input  wire logic                           wvalid,
	output logic                                wready,

	// Write response.
	output logic      [1:0]                     bresp,
	output logic                                bvalid,
	input  wire logic                           bready,

	// Read address and data.
	input  wire logic [AXIL_ADDR_W-1:0]         araddr,
	input  wire logic                           arvalid,
	output logic                                arready,
	output logic      [AXIL_DATA_W-1:0]         rdata,
	output logic      [1:0]                     rresp,
	output logic                                rvalid,
	input  wire logic                           rready,

	output logic                                enable,
	output logic      [7:0]                     sample_div,
	output logic                                snap_irq
);

	// Word offsets of the register map.
	localparam int STATUS_W = int'(REG_STATUS) / 4;
	localparam int CTRL_W = int'(REG_CTRL) / 4;
	localparam int AUTO_W = int'(REG_AUTO_BASE) / 4;
	localparam int CROSS_W = int'(REG_CROSS_BASE) / 4;

	// Snapshot of both banks.
	logic [COUNT_W-1:0]     snap_auto [NUM_LINES];
	logic [COUNT_W-1:0]     snap_cross [NUM_CROSS];
	logic                   snap_valid;
	logic [15:0]            snap_seq;

	logic                   wr_accept;
	logic                   rd_accept;
	logic [AXIL_DATA_W-1:0] rd_word;

	// ############################
	// Snapshot.
	// ############################

	// Counters clear on the same edge, so this is the final count.
	always_ff @(posedge clki) begin
		if (integ_end) begin
			for (int k = 0; k < NUM_LINES; k++) begin
				snap_auto[k] <= auto_counts[k*COUNT_W +: COUNT_W];
			end
			for (int k = 0; k < NUM_CROSS; k++) begin
				snap_cross[k] <= cross_counts[k*COUNT_W +: COUNT_W];
			end
		end
	end

	always_ff @(posedge clki) begin
		if (rst) begin
			snap_valid <= 1'b0;
			snap_seq   <= '0;
			snap_irq   <= 1'b0;
		end else begin
			snap_irq <= integ_end;
			if (integ_end) begin
				snap_valid <= 1'b1;
				snap_seq   <= snap_seq + 16'd1;
			end
		end
	end

	// ############################
	// Write channel.
	// ############################

	// Address and data taken together, once the last response is gone.
	assign wr_accept = awvalid && wvalid && !bvalid;
	assign awready   = wr_accept;
	assign wready    = wr_accept;
	assign bresp     = AXIL_RESP_OKAY;

	always_ff @(posedge clki) begin
		if (rst) begin
			bvalid     <= 1'b0;
			enable     <= 1'b0;
			sample_div <= '0;
		end else begin
			if (wr_accept) begin
				bvalid <= 1'b1;
			end else if (bready) begin
				bvalid <= 1'b0;
			end
			// Control is the only writable register.
			if (wr_accept && awaddr[AXIL_ADDR_W-1:2] == REG_CTRL[AXIL_ADDR_W-1:2]) begin
				if (wstrb[0]) begin
					enable <= wdata[0];
				end
				if (wstrb[1]) begin
					sample_div <= wdata[15:8];
				end
			end
		end
	end

	// ############################
	// Read channel.
	// ############################

	assign arready   = !rvalid;
	assign rd_accept = arvalid && arready;
	assign rresp     = AXIL_RESP_OKAY;

	// Address decode, unmapped words read as zero.
	always_comb begin
		int word_i;
		rd_word = '0;
		word_i  = int'(araddr[AXIL_ADDR_W-1:2]);
		if (word_i == STATUS_W) begin
			rd_word[31]   = snap_valid;
			rd_word[15:0] = snap_seq;
		end else if (word_i == CTRL_W) begin
			rd_word[0]    = enable;
			rd_word[15:8] = sample_div;
		end else if (word_i >= AUTO_W && word_i < AUTO_W + NUM_LINES) begin
			rd_word[COUNT_W-1:0] = snap_auto[word_i-AUTO_W];
		end else if (word_i >= CROSS_W && word_i < CROSS_W + NUM_CROSS) begin
			rd_word[COUNT_W-1:0] = snap_cross[word_i-CROSS_W];
		end
	end

	// Data is latched at the address phase and held until rready.
	always_ff @(posedge clki) begin
		if (rd_accept) begin
			rdata <= rd_word;
		end
	end

	always_ff @(posedge clki) begin
		if (rst) begin
			rvalid <= 1'b0;
		end else if (rd_accept) begin
			rvalid <= 1'b1;
		end else if (rready) begin
			rvalid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* rtl/xc_cross_counters.sv */
// Lag-correlation engine: one coincidence counter per line pair and lag.
// Needs NUM_LINES of at least 2. Counters saturate and clear on integ_end.
// Output order is pair-major, lag-minor, as in the register map.

`timescale 1ns/100ps
`default_nettype none

module xc_cross_counters
	import xc_pkg::*;
#(
	parameter int NUM_LINES = 4,
	parameter int MAX_LAG = 2,
	parameter int COUNT_W = 24,
	localparam int NUM_PAIRS = xc_pair_index(NUM_LINES - 2, NUM_LINES - 1, NUM_LINES) + 1,
	localparam int NUM_CROSS = NUM_PAIRS * MAX_LAG
) (
	input  wire logic                           clki,
	input  wire logic                           rst,
	input  wire logic                           sample_valid,
	input  wire logic [NUM_LINES*MAX_LAG-1:0]   sample_hist,
	input  wire logic                           integ_active,
	input  wire logic                           integ_end,
	output logic      [NUM_CROSS*COUNT_W-1:0]   cross_counts
);

	// Strobe inside the integration window.
	logic count_en;

	assign count_en = sample_valid & integ_active;

	// ############################
	// Pair and lag array.
	// ############################

	genvar gi;
	genvar gj;
	genvar gl;
	generate
		for (gi = 0; gi < NUM_LINES - 1; gi++) begin : g_i
			for (gj = gi + 1; gj < NUM_LINES; gj++) begin : g_j
				for (gl = 0; gl < MAX_LAG; gl++) begin : g_lag
					// Flat slot of this pair and lag.
					localparam int IDX = xc_pair_index(gi, gj, NUM_LINES) * MAX_LAG + gl;

					logic [COUNT_W-1:0] cnt;
					logic               hit;

					// Line i now, line j gl samples back.
					assign hit = sample_hist[gi] & sample_hist[gl*NUM_LINES + gj];

					always_ff @(posedge clki) begin
						if (rst || integ_end) begin
							cnt <= '0;
						end else if (count_en && hit && !(&cnt)) begin
							cnt <= cnt + 1'b1;
						end
					end

					assign cross_counts[IDX*COUNT_W +: COUNT_W] = cnt;
				end
			end
		end
	endgenerate

endmodule

`default_nettype wire

/* rtl/xc_auto_counters.sv */
// Per-line ones counters for one integration.
// Counters saturate at all ones and clear on integ_end.

`timescale 1ns/100ps
`default_nettype none

module xc_auto_counters #(
	parameter int NUM_LINES = 4,
	parameter int MAX_LAG = 2,
	parameter int COUNT_W = 24
) (
	input  wire logic                           clki,
	input  wire logic                           rst,
	input  wire logic                           sample_valid,
	input  wire logic [NUM_LINES*MAX_LAG-1:0]   sample_hist,
	input  wire logic                           integ_active,
	input  wire logic                           integ_end,
	output logic      [NUM_LINES*COUNT_W-1:0]   auto_counts
);

	// Strobe that falls inside the integration window.
	logic count_en;

	assign count_en = sample_valid & integ_active;

	genvar gi;
	generate
		for (gi = 0; gi < NUM_LINES; gi++) begin : g_line
			logic [COUNT_W-1:0] cnt;

			// Only the current sample, slice 0, matters here.
			always_ff @(posedge clki) begin
				if (rst || integ_end) begin
					cnt <= '0;
				end else if (count_en && sample_hist[gi] && !(&cnt)) begin
					cnt <= cnt + 1'b1;
				end
			end

			assign auto_counts[gi*COUNT_W +: COUNT_W] = cnt;
		end
	endgenerate

endmodule

`default_nettype wire

/* rtl/xc_sampler.sv */
// Line and integration synchronizer with sample strobe and lag history.
// line_in and integrating share one two-stage synchronizer, so they stay aligned.
// MAX_LAG of 1 keeps no history; sample_hist is then the current sample only.

`timescale 1ns/100ps
`default_nettype none

module xc_sampler #(
	parameter int NUM_LINES = 4,
	parameter int MAX_LAG = 2
) (
	input  wire logic                           clki,
	input  wire logic                           rst,
	input  wire logic [NUM_LINES-1:0]           line_in,
	input  wire logic                           integrating,
	input  wire logic                           enable,
	input  wire logic [7:0]                     sample_div,
	output logic                                sample_valid,
	output logic      [NUM_LINES*MAX_LAG-1:0]   sample_hist,
	output logic                                integ_active,
	output logic                                integ_end
);

	// Two-stage synchronizers.
	logic [NUM_LINES-1:0] line_s1;
	logic [NUM_LINES-1:0] line_s2;
	logic                 integ_s1;
	logic                 integ_s2;
	logic                 integ_prev;

	// Divider count since last strobe.
	logic [7:0]           div_cnt;

	// Line synchronizer.
	always_ff @(posedge clki) begin
		line_s1 <= line_in;
		line_s2 <= line_s1;
	end

	always_ff @(posedge clki) begin
		if (rst) begin
			integ_s1   <= 1'b0;
			integ_s2   <= 1'b0;
			integ_prev <= 1'b0;
		end else begin
			integ_s1   <= integrating;
			integ_s2   <= integ_s1;
			integ_prev <= integ_s2;
		end
	end

	assign integ_active = integ_s2;

	// Falling edge of the synchronized flag.
	assign integ_end = integ_prev & ~integ_s2;

	// ############################
	// Sample strobe.
	// ############################

	// One strobe every sample_div+1 cycles.
	// The >= guards against a divider lowered mid-count.
	assign sample_valid = enable && (div_cnt >= sample_div);

	always_ff @(posedge clki) begin
		if (rst || !enable) begin
			div_cnt <= '0;
		end else if (sample_valid) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 8'd1;
		end
	end

	// ############################
	// Lag history.
	// ############################

	// Slice 0 is the live synchronized sample, older slices come from strobes.
	generate
		if (MAX_LAG > 1) begin : g_hist
			logic [NUM_LINES*(MAX_LAG-1)-1:0] hist_q;

			always_ff @(posedge clki) begin
				if (rst) begin
					hist_q <= '0;
				end else if (sample_valid) begin
					// Oldest slice drops off the top.
					for (int k = MAX_LAG - 2; k > 0; k--) begin
						hist_q[k*NUM_LINES +: NUM_LINES] <= hist_q[(k-1)*NUM_LINES +: NUM_LINES];
					end
					hist_q[0 +: NUM_LINES] <= line_s2;
				end
			end

			assign sample_hist = {hist_q, line_s2};
		end else begin : g_nohist
			assign sample_hist = line_s2;
		end
	endgenerate

endmodule

`default_nettype wire

/* rtl/xc_pkg.sv */
// Shared widths, AXI4-Lite register map and pair numbering of the correlator.
// Register offsets are byte addresses and are word aligned.
// The map leaves room for 12 auto entries and 48 cross entries.

`default_nettype none

package xc_pkg;

	// ############################
	// Bus widths.
	// ############################

	localparam int AXIL_ADDR_W = 8;
	localparam int AXIL_DATA_W = 32;

	// OKAY response, the only one this slave returns.
	localparam logic [1:0] AXIL_RESP_OKAY = 2'b00;

	// ############################
	// Register map.
	// ############################

	// Bit 31 snapshot valid, bits 15:0 sequence number.
	localparam logic [AXIL_ADDR_W-1:0] REG_STATUS = 8'h00;

	// Bit 0 enable, bits 15:8 sample divider.
	localparam logic [AXIL_ADDR_W-1:0] REG_CTRL = 8'h04;

	// Auto count of line i at base + 4*i.
	localparam logic [AXIL_ADDR_W-1:0] REG_AUTO_BASE = 8'h10;

	// Cross count of pair p, lag l at base + 4*(p*MAX_LAG + l).
	localparam logic [AXIL_ADDR_W-1:0] REG_CROSS_BASE = 8'h40;

	// ############################
	// Pair numbering.
	// ############################

	// Pairs (i,j) with i<j, numbered row by row.
	// Row i starts after i rows of shrinking length.
	function automatic int xc_pair_index(input int i, input int j, input int n);
		int row_start;
		row_start = i * n - (i * (i + 1)) / 2;
		return row_start + (j - i - 1);
	endfunction

endpackage

`default_nettype wire
